// ==== ahb_pkg.sv ====
// AHB-Lite bus definitions
package ahb_pkg;

  // ---------------------------------------------------------
  // Bus widths
  // ---------------------------------------------------------
  localparam int ADDR_W  = 16;  // Byte address for a 64 KB device
  localparam int HDATA_W = 32;  // HWDATA and HRDATA

  // ---------------------------------------------------------
  // Encodings
  // ---------------------------------------------------------
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,  // First beat of a transfer
    SEQ    = 2'b11   // Later beats of a burst
  } htrans_e;

  // Sizes up to the bus width only
  typedef enum logic [2:0] {
    SIZE_BYTE = 3'b000,
    SIZE_HALF = 3'b001,
    SIZE_WORD = 3'b010
  } hsize_e;

endpackage

// ==== ext_mem_pkg.sv ====
// External SRAM port definitions
package ext_mem_pkg;

  // ---------------------------------------------------------
  // Memory port widths
  // ---------------------------------------------------------
  localparam int MDATA_W = 16;  // Widest supported data port
  localparam int CYC_W   = 3;   // Wait count fields, 0 to 7 extra cycles
  localparam int LANES   = 2;   // Byte lanes on the data port

  // ---------------------------------------------------------
  // Port size selection
  // ---------------------------------------------------------
  // Static strap, held stable while the bridge is busy
  typedef enum logic {
    PORT_8  = 1'b0,  // Data on bits 7..0 only
    PORT_16 = 1'b1   // Both lanes in use
  } port_size_e;

endpackage

// ==== ahb_access_ctrl.sv ====
// AHB transfer capture and access split
module ahb_access_ctrl (
  input  logic                          HCLK,
  input  logic                          HRESETn,
  input  logic                          hsel,          // Slave select
  input  logic [ahb_pkg::ADDR_W-1:0]    haddr,         // Address phase address
  input  ahb_pkg::htrans_e              htrans,
  input  ahb_pkg::hsize_e               hsize,
  input  logic                          hwrite,
  input  logic                          hready,        // Previous transfer finished
  input  ext_mem_pkg::port_size_e       cfg_size,      // Memory port width
  input  logic                          done,          // Memory access finished
  output logic                          hreadyout,
  output logic [ahb_pkg::ADDR_W-1:0]    mem_addr,      // Address of current access
  output logic                          rd_req,        // Read access pending
  output logic                          wr_req,        // Write access pending
  output logic [ext_mem_pkg::LANES-1:0] nxt_byte_mask  // Lanes for pending access
);

  // Split states
  // Each state names the access now running, DEF being the last one
  typedef enum logic [2:0] {
    DEF  = 3'd0,  // Only or final access
    W8_A = 3'd1,  // Word on 8-bit port, byte 0
    W8_B = 3'd2,  // Word on 8-bit port, byte 1
    W8_C = 3'd3,  // Word on 8-bit port, byte 2
    W16  = 3'd4,  // Word on 16-bit port, low half
    H8   = 3'd5   // Half on 8-bit port, low byte
  } split_state_e;

  split_state_e    state;        // Current split step
  split_state_e    first_state;  // Step to enter on a new transfer
  ahb_pkg::hsize_e size_q;       // Data phase transfer size
  logic            trans_valid;  // Address phase for this slave
  logic            port16;

  // ---------------------------------------------------------
  // Address phase decode
  // ---------------------------------------------------------
  assign port16      = (cfg_size == ext_mem_pkg::PORT_16);
  assign trans_valid = hsel & hready &
                       ((htrans == ahb_pkg::NONSEQ) | (htrans == ahb_pkg::SEQ));

  // Number of memory accesses follows size and port width
  always_comb
  begin
    first_state = DEF;  // Byte, or half on 16-bit port
    if (hsize == ahb_pkg::SIZE_WORD)
    begin
      first_state = port16 ? W16 : W8_A;
    end
    else if ((hsize == ahb_pkg::SIZE_HALF) && !port16)
    begin
      first_state = H8;
    end
  end

  // Size only feeds the lane mask
  always_ff @(posedge HCLK)
  begin
    if (trans_valid)
    begin
      size_q <= hsize;
    end
  end

  // ---------------------------------------------------------
  // Split FSM, address and handshake
  // ---------------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state     <= DEF;
      mem_addr  <= '0;
      rd_req    <= 1'b0;
      wr_req    <= 1'b0;
      hreadyout <= 1'b1;
    end
    else if (trans_valid)
    begin
      state     <= first_state;
      mem_addr  <= haddr;     // First access at the transfer address
      rd_req    <= !hwrite;
      wr_req    <= hwrite;
      hreadyout <= 1'b0;      // Stall until last access done
    end
    else if (done)
    begin
      case (state)
        W8_A:
        begin
          state         <= W8_B;
          mem_addr[1:0] <= 2'b01;
        end
        W8_B:
        begin
          state         <= W8_C;
          mem_addr[1:0] <= 2'b10;
        end
        W8_C:
        begin
          state         <= DEF;
          mem_addr[1:0] <= 2'b11;
        end
        W16:
        begin
          state       <= DEF;
          mem_addr[1] <= 1'b1;  // Upper halfword
        end
        H8:
        begin
          state       <= DEF;
          mem_addr[0] <= 1'b1;  // Upper byte of the half
        end
        default:
        begin
          // Transfer complete, release the bus
          rd_req    <= 1'b0;
          wr_req    <= 1'b0;
          hreadyout <= 1'b1;
        end
      endcase
    end
  end

  // ---------------------------------------------------------
  // Byte lane mask
  // ---------------------------------------------------------
  always_comb
  begin
    if (!port16)
    begin
      nxt_byte_mask = 2'b01;  // 8-bit devices sit on the lower lane
    end
    else if (size_q == ahb_pkg::SIZE_BYTE)
    begin
      nxt_byte_mask = mem_addr[0] ? 2'b10 : 2'b01;  // Odd byte on upper lane
    end
    else
    begin
      nxt_byte_mask = 2'b11;
    end
  end

endmodule

// ==== data_lane_router.sv ====
// Memory data lane steering
module data_lane_router (
  input  logic                            HCLK,
  input  logic                            HRESETn,
  input  logic [ahb_pkg::HDATA_W-1:0]     hwdata,    // Held by master while stalled
  input  logic [ext_mem_pkg::MDATA_W-1:0] data_in,   // SRAM read data
  input  logic [ahb_pkg::ADDR_W-1:0]      mem_addr,  // Address of current access
  input  ext_mem_pkg::port_size_e         cfg_size,
  input  logic                            rd_req,
  input  logic                            done,
  output logic [ext_mem_pkg::MDATA_W-1:0] data_out,  // SRAM write data
  output logic [ahb_pkg::HDATA_W-1:0]     hrdata
);

  logic [1:0]                      lane_sel;    // Byte offset inside the word
  logic [7:0]                      wr_byte;     // Byte slice for 8-bit port
  logic [ext_mem_pkg::MDATA_W-1:0] wr_half;     // Half slice for 16-bit port
  logic                            rd_capture;  // Read data valid this cycle
  logic [ahb_pkg::HDATA_W-1:0]     rdata_q;     // Assembled read word

  assign lane_sel   = mem_addr[1:0];
  assign rd_capture = rd_req & done;  // Last cycle of a read access

  // ---------------------------------------------------------
  // Write path
  // ---------------------------------------------------------
  always_comb
  begin
    case (lane_sel)
      2'd0:    wr_byte = hwdata[7:0];
      2'd1:    wr_byte = hwdata[15:8];
      2'd2:    wr_byte = hwdata[23:16];
      default: wr_byte = hwdata[31:24];
    endcase
    wr_half = lane_sel[1] ? hwdata[31:16] : hwdata[15:0];
  end

  // Byte copied to both lanes on a narrow port
  // The upper lane is never enabled there
  assign data_out = (cfg_size == ext_mem_pkg::PORT_16) ? wr_half : {wr_byte, wr_byte};

  // ---------------------------------------------------------
  // Read path
  // ---------------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      rdata_q <= '0;
    end
    else if (rd_capture)
    begin
      if (cfg_size == ext_mem_pkg::PORT_16)
      begin
        // Whole half stored, AHB picks its own bytes
        if (lane_sel[1])
        begin
          rdata_q[31:16] <= data_in;
        end
        else
        begin
          rdata_q[15:0] <= data_in;
        end
      end
      else
      begin
        case (lane_sel)
          2'd0:    rdata_q[7:0]   <= data_in[7:0];
          2'd1:    rdata_q[15:8]  <= data_in[7:0];
          2'd2:    rdata_q[23:16] <= data_in[7:0];
          default: rdata_q[31:24] <= data_in[7:0];
        endcase
      end
    end
  end

  assign hrdata = rdata_q;  // Valid once HREADYOUT returns high

endmodule

// ==== mem_cycle_fsm.sv ====
// External SRAM cycle timing
module mem_cycle_fsm (
  input  logic                          HCLK,
  input  logic                          HRESETn,
  input  logic                          rd_req,               // Read access pending
  input  logic                          wr_req,               // Write access pending
  input  logic [ext_mem_pkg::LANES-1:0] nxt_byte_mask,        // Lanes of pending access
  input  logic [ext_mem_pkg::CYC_W-1:0] cfg_read_cycle,       // Extra OEn low cycles
  input  logic [ext_mem_pkg::CYC_W-1:0] cfg_write_cycle,      // Extra WEn low cycles
  input  logic [ext_mem_pkg::CYC_W-1:0] cfg_turnaround_cycle, // Gap after a read
  output logic                          done,                 // Access finished
  output logic                          ce_n,
  output logic                          oe_n,
  output logic                          we_n,
  output logic                          data_oe_n,            // Drive write data
  output logic                          lb_n,
  output logic                          ub_n
);

  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    WRITE1 = 3'd1,  // Address and data setup
    WRITE2 = 3'd2,  // WEn low
    WRITE3 = 3'd3,  // Hold
    READ1  = 3'd4,  // CEn and OEn low
    TURN   = 3'd5   // Bus turnaround
  } mem_state_e;

  mem_state_e                    state;
  mem_state_e                    nxt_state;
  logic [ext_mem_pkg::CYC_W-1:0] cnt;        // Wait cycle down-counter
  logic [ext_mem_pkg::CYC_W-1:0] nxt_cnt;
  logic [ext_mem_pkg::LANES-1:0] byte_mask;  // Held for the whole access
  logic [ext_mem_pkg::LANES-1:0] nxt_mask;
  logic                          start;      // Request accepted
  logic                          cnt_zero;
  logic                          off_nxt;    // Chip deselected next cycle

  assign cnt_zero = (cnt == '0);

  // New access from IDLE, a read may also cut a turnaround short
  assign start = ((state == IDLE) & (rd_req | wr_req)) | ((state == TURN) & rd_req);
  assign nxt_mask = start ? nxt_byte_mask : byte_mask;

  // Last read cycle or write hold cycle
  assign done = ((state == READ1) & cnt_zero) | (state == WRITE3);

  // ---------------------------------------------------------
  // Next state
  // ---------------------------------------------------------
  always_comb
  begin
    nxt_state = state;
    nxt_cnt   = cnt;
    case (state)
      IDLE, TURN:
      begin
        if (start && rd_req)
        begin
          nxt_state = READ1;
          nxt_cnt   = cfg_read_cycle;
        end
        else if (start)
        begin
          nxt_state = WRITE1;
        end
        else if (state == TURN)
        begin
          if (cnt_zero)
          begin
            nxt_state = IDLE;
          end
          else
          begin
            nxt_cnt = cnt - 1'b1;
          end
        end
      end
      READ1:
      begin
        if (cnt_zero && (cfg_turnaround_cycle != '0))
        begin
          nxt_state = TURN;
          nxt_cnt   = cfg_turnaround_cycle - 1'b1;
        end
        else if (cnt_zero)
        begin
          nxt_state = IDLE;
        end
        else
        begin
          nxt_cnt = cnt - 1'b1;
        end
      end
      WRITE1:
      begin
        nxt_state = WRITE2;
        nxt_cnt   = cfg_write_cycle;
      end
      WRITE2:
      begin
        if (cnt_zero)
        begin
          nxt_state = WRITE3;
        end
        else
        begin
          nxt_cnt = cnt - 1'b1;
        end
      end
      default: nxt_state = IDLE;  // WRITE3 ends the write
    endcase
  end

  assign off_nxt = (nxt_state == IDLE) | (nxt_state == TURN);

  // ---------------------------------------------------------
  // State and registered strobes
  // ---------------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state     <= IDLE;
      cnt       <= '0;
      ce_n      <= 1'b1;
      oe_n      <= 1'b1;
      we_n      <= 1'b1;
      data_oe_n <= 1'b1;
      lb_n      <= 1'b1;
      ub_n      <= 1'b1;
    end
    else
    begin
      state     <= nxt_state;
      cnt       <= nxt_cnt;
      ce_n      <= off_nxt;
      oe_n      <= (nxt_state != READ1);
      we_n      <= (nxt_state != WRITE2);
      data_oe_n <= !((nxt_state == WRITE1) | (nxt_state == WRITE2) | (nxt_state == WRITE3));
      lb_n      <= off_nxt | !nxt_mask[0];
      ub_n      <= off_nxt | !nxt_mask[1];
    end
  end

  always_ff @(posedge HCLK)
  begin
    byte_mask <= nxt_mask;
  end

endmodule

// ==== ahb_to_extmem.sv ====
// AHB-Lite to external SRAM bridge
module ahb_to_extmem (
  input  logic                            HCLK,
  input  logic                            HRESETn,
  // AHB-Lite slave
  input  logic                            hsel,
  input  logic [ahb_pkg::ADDR_W-1:0]      haddr,
  input  ahb_pkg::htrans_e                htrans,
  input  ahb_pkg::hsize_e                 hsize,
  input  logic                            hwrite,
  input  logic [ahb_pkg::HDATA_W-1:0]     hwdata,
  input  logic                            hready,
  output logic                            hreadyout,
  output logic [ahb_pkg::HDATA_W-1:0]     hrdata,
  // Static configuration
  input  logic [ext_mem_pkg::CYC_W-1:0]   cfg_read_cycle,
  input  logic [ext_mem_pkg::CYC_W-1:0]   cfg_write_cycle,
  input  logic [ext_mem_pkg::CYC_W-1:0]   cfg_turnaround_cycle,
  input  ext_mem_pkg::port_size_e         cfg_size,
  // SRAM pins
  input  logic [ext_mem_pkg::MDATA_W-1:0] data_in,
  output logic [ahb_pkg::ADDR_W-1:0]      addr,
  output logic [ext_mem_pkg::MDATA_W-1:0] data_out,
  output logic                            data_oe_n,  // Tristate enable for data_out
  output logic                            we_n,
  output logic                            oe_n,
  output logic                            ce_n,
  output logic                            lb_n,
  output logic                            ub_n
);

  // ---------------------------------------------------------
  // Request and done between bus side and memory side
  // ---------------------------------------------------------
  logic                          rd_req;
  logic                          wr_req;
  logic                          done;
  logic [ext_mem_pkg::LANES-1:0] nxt_byte_mask;

  // Split of each transfer into memory accesses
  ahb_access_ctrl u_access_ctrl (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .hsel          (hsel),
    .haddr         (haddr),
    .htrans        (htrans),
    .hsize         (hsize),
    .hwrite        (hwrite),
    .hready        (hready),
    .cfg_size      (cfg_size),
    .done          (done),
    .hreadyout     (hreadyout),
    .mem_addr      (addr),        // Straight to the address pins
    .rd_req        (rd_req),
    .wr_req        (wr_req),
    .nxt_byte_mask (nxt_byte_mask)
  );

  // Data steering in both directions
  data_lane_router u_lane_router (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .hwdata   (hwdata),
    .data_in  (data_in),
    .mem_addr (addr),
    .cfg_size (cfg_size),
    .rd_req   (rd_req),
    .done     (done),
    .data_out (data_out),
    .hrdata   (hrdata)
  );

  // Strobe timing per access
  mem_cycle_fsm u_cycle_fsm (
    .HCLK                 (HCLK),
    .HRESETn              (HRESETn),
    .rd_req               (rd_req),
    .wr_req               (wr_req),
    .nxt_byte_mask        (nxt_byte_mask),
    .cfg_read_cycle       (cfg_read_cycle),
    .cfg_write_cycle      (cfg_write_cycle),
    .cfg_turnaround_cycle (cfg_turnaround_cycle),
    .done                 (done),
    .ce_n                 (ce_n),
    .oe_n                 (oe_n),
    .we_n                 (we_n),
    .data_oe_n            (data_oe_n),
    .lb_n                 (lb_n),
    .ub_n                 (ub_n)
  );

endmodule

// ==== tb_ahb_to_extmem.sv ====
// AHB to SRAM bridge testbench
module tb_ahb_to_extmem;

  localparam int PERIOD    = 100;
  localparam int N_TAB     = 18;
  localparam int N_RAND    = 40;
  localparam int WORST_ACC = 20;  // Cycles per access incl. turnaround and gaps
  localparam int WATCHDOG  = ((N_TAB + N_RAND) * WORST_ACC * 4 + 100) * PERIOD;

  logic                   HCLK = 1'b0;
  logic                   HRESETn;
  logic                   hsel;
  logic [15:0]            haddr;
  ahb_pkg::htrans_e       htrans;
  ahb_pkg::hsize_e        hsize;
  logic                   hwrite;
  logic [31:0]            hwdata;
  logic                   hready;
  logic                   hreadyout;
  logic [31:0]            hrdata;
  logic [2:0]             cfg_read_cycle;
  logic [2:0]             cfg_write_cycle;
  logic [2:0]             cfg_turnaround_cycle;
  ext_mem_pkg::port_size_e cfg_size;
  logic [15:0]            data_in;
  logic [15:0]            addr;
  logic [15:0]            data_out;
  logic                   data_oe_n, we_n, oe_n, ce_n, lb_n, ub_n;

  logic [7:0]  mem    [0:65535];  // SRAM contents
  logic [7:0]  shadow [0:65535];  // Expected contents
  integer      seed   = 21927;
  int          errors = 0;
  int          oe_len = 0;
  int          we_len = 0;
  logic [15:0] addr_hold;
  logic [1:0]  lane_hold;

  // Stimulus table
  logic        t_port  [N_TAB];
  logic [2:0]  t_rc    [N_TAB];
  logic [2:0]  t_wc    [N_TAB];
  logic [2:0]  t_tc    [N_TAB];
  logic        t_wr    [N_TAB];
  logic [2:0]  t_size  [N_TAB];
  logic [15:0] t_addr  [N_TAB];
  logic [31:0] t_wdata [N_TAB];
  logic [31:0] t_exp   [N_TAB];
  int          t_cnt = 0;

  always #(PERIOD / 2) HCLK = ~HCLK;

  ahb_to_extmem dut_i (
    .HCLK (HCLK), .HRESETn (HRESETn), .hsel (hsel), .haddr (haddr), .htrans (htrans),
    .hsize (hsize), .hwrite (hwrite), .hwdata (hwdata), .hready (hready),
    .hreadyout (hreadyout), .hrdata (hrdata), .cfg_read_cycle (cfg_read_cycle),
    .cfg_write_cycle (cfg_write_cycle), .cfg_turnaround_cycle (cfg_turnaround_cycle),
    .cfg_size (cfg_size), .data_in (data_in), .addr (addr), .data_out (data_out),
    .data_oe_n (data_oe_n), .we_n (we_n), .oe_n (oe_n), .ce_n (ce_n),
    .lb_n (lb_n), .ub_n (ub_n)
  );

  // ------------------------------------------------------------
  // SRAM model
  // ------------------------------------------------------------
  always_comb
  begin
    if (!ce_n && !oe_n)
      data_in = (cfg_size == ext_mem_pkg::PORT_16) ?
                {mem[{addr[15:1], 1'b1}], mem[{addr[15:1], 1'b0}]} : {8'h00, mem[addr]};
    else
      data_in = 16'h0000;
  end

  always @(posedge we_n)  // Write on the trailing edge
  begin
    if (cfg_size == ext_mem_pkg::PORT_16)
    begin
      if (!lb_n) mem[{addr[15:1], 1'b0}] = data_out[7:0];
      if (!ub_n) mem[{addr[15:1], 1'b1}] = data_out[15:8];
    end
    else if (!lb_n)
    begin
      mem[addr] = data_out[7:0];
    end
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
  endtask

  // ------------------------------------------------------------
  // Strobe timing monitor
  // ------------------------------------------------------------
  always @(posedge HCLK)
  begin
    if (HRESETn)
    begin
      if (!oe_n)
      begin
        oe_len++;
        check("data_oe_n", 32'(data_oe_n), 32'd1);  // SRAM owns the data bus
      end
      else if (oe_len != 0)
      begin
        check("oe_n low cycles", 32'(oe_len), 32'(cfg_read_cycle) + 32'd1);
        oe_len = 0;
      end
      if (!we_n)
      begin
        if (we_len == 0)
        begin
          addr_hold = addr;  // Reference for stability
          lane_hold = {ub_n, lb_n};
        end
        else
        begin
          check("addr", 32'(addr), 32'(addr_hold));
          check("ub_n/lb_n", 32'({ub_n, lb_n}), 32'(lane_hold));
        end
        check("data_oe_n", 32'(data_oe_n), 32'd0);  // Write data driven
        we_len++;
      end
      else if (we_len != 0)
      begin
        check("we_n low cycles", 32'(we_len), 32'(cfg_write_cycle) + 32'd1);
        we_len = 0;
      end
      if (cfg_size == ext_mem_pkg::PORT_8) check("ub_n", 32'(ub_n), 32'd1);
    end
  end

  task automatic check_idle_pins();
    check("ce_n", 32'(ce_n), 32'd1);
    check("oe_n", 32'(oe_n), 32'd1);
    check("we_n", 32'(we_n), 32'd1);
    check("lb_n", 32'(lb_n), 32'd1);
    check("ub_n", 32'(ub_n), 32'd1);
    check("data_oe_n", 32'(data_oe_n), 32'd1);
    check("hreadyout", 32'(hreadyout), 32'd1);
  endtask

  task automatic add_entry(input logic p, input logic [2:0] rc, wc, tc, input logic wr,
                           input logic [2:0] sz, input logic [15:0] a,
                           input logic [31:0] wd, exp);
    t_port[t_cnt]  = p;
    t_rc[t_cnt]    = rc;
    t_wc[t_cnt]    = wc;
    t_tc[t_cnt]    = tc;
    t_wr[t_cnt]    = wr;
    t_size[t_cnt]  = sz;
    t_addr[t_cnt]  = a;
    t_wdata[t_cnt] = wd;
    t_exp[t_cnt]   = exp;
    t_cnt++;
  endtask

  // Bytes of the word that a transfer covers
  function automatic logic [31:0] lane_mask(input logic [2:0] sz, input logic [15:0] a);
    if (sz == 3'd2) return 32'hFFFF_FFFF;
    if (sz == 3'd1) return 32'h0000_FFFF << (16 * a[1]);
    return 32'h0000_00FF << (8 * a[1:0]);
  endfunction

  function automatic logic [31:0] shadow_word(input logic [15:0] a);
    return {shadow[{a[15:2], 2'd3}], shadow[{a[15:2], 2'd2}],
            shadow[{a[15:2], 2'd1}], shadow[{a[15:2], 2'd0}]};
  endfunction

  // Little-endian shadow update and compare of model bytes
  task automatic record_write(input logic [2:0] sz, input logic [15:0] a,
                              input logic [31:0] wd);
    logic [15:0] nb;
    logic [15:0] ad;
    nb = 16'd1 << sz;
    for (logic [15:0] i = 0; i < nb; i++)
    begin
      ad = (a & ~(nb - 16'd1)) + i;
      shadow[ad] = wd[8 * ad[1:0] +: 8];
      check($sformatf("mem[%h]", ad), 32'(mem[ad]), 32'(shadow[ad]));
    end
  endtask

  // One AHB transfer that returns once HREADYOUT is high again
  task automatic run_transfer(input logic p, input logic [2:0] rc, wc, tc, input logic wr,
                              input logic [2:0] sz, input logic [15:0] a,
                              input logic [31:0] wd, input int gaps);
    cfg_size             <= ext_mem_pkg::port_size_e'(p);
    cfg_read_cycle       <= rc;
    cfg_write_cycle      <= wc;
    cfg_turnaround_cycle <= tc;
    hsel   <= 1'b1;
    haddr  <= a;
    htrans <= ahb_pkg::NONSEQ;
    hsize  <= ahb_pkg::hsize_e'(sz);
    hwrite <= wr;
    hready <= (gaps == 0);  // Bus still busy elsewhere
    for (int g = 0; g < gaps; g++)
    begin
      @(posedge HCLK);
      if (g != 0) check("hreadyout", 32'(hreadyout), 32'd1);  // Not taken while hready low
      if (g == gaps - 1) hready <= 1'b1;
    end
    @(posedge HCLK);  // Address phase taken
    if (gaps != 0) check("hreadyout", 32'(hreadyout), 32'd1);
    htrans <= ahb_pkg::IDLE;
    hsel   <= 1'b0;
    hwdata <= wd;
    do @(posedge HCLK); while (hreadyout !== 1'b1);
  endtask

  initial
  begin
    #(WATCHDOG);
    $display("Watchdog expired, the DUT stopped responding");
    $display("Test failed");
    $finish;
  end

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial
  begin
    int          err0;
    logic [31:0] rnd;
    logic [2:0]  sz;
    logic [15:0] a;
    logic        p;
    logic        wr;
    logic [2:0]  rc, wc, tc;
    logic [31:0] wd;
    int          gaps;

    HRESETn              = 1'b0;
    hsel                 = 1'b0;
    haddr                = 16'h0;
    htrans               = ahb_pkg::IDLE;
    hsize                = ahb_pkg::SIZE_BYTE;
    hwrite               = 1'b0;
    hwdata               = 32'h0;
    hready               = 1'b1;
    cfg_read_cycle       = 3'd0;
    cfg_write_cycle      = 3'd0;
    cfg_turnaround_cycle = 3'd0;
    cfg_size             = ext_mem_pkg::PORT_16;
    for (int i = 0; i < 65536; i++)
    begin
      mem[16'(i)]    = 8'(i ^ (i >> 8) ^ 32'h5A);  // Pattern from the whole address
      shadow[16'(i)] = mem[16'(i)];
    end

    // Port, rc, wc, tc, write, size, address, write data, read data
    add_entry(1, 0, 0, 0, 1, 2, 16'h0100, 32'h4433_2211, 32'h0);
    add_entry(1, 1, 2, 1, 0, 2, 16'h0100, 32'h0,         32'h4433_2211);
    add_entry(1, 2, 1, 0, 1, 0, 16'h0201, 32'h0000_AB00, 32'h0);
    add_entry(1, 0, 0, 0, 0, 0, 16'h0201, 32'h0,         32'h0000_AB00);
    add_entry(1, 3, 3, 2, 1, 1, 16'h0302, 32'hBEEF_0000, 32'h0);
    add_entry(1, 1, 0, 1, 0, 1, 16'h0302, 32'h0,         32'hBEEF_0000);
    add_entry(0, 0, 1, 0, 1, 2, 16'h0400, 32'hCAFE_F00D, 32'h0);
    add_entry(0, 2, 0, 1, 0, 2, 16'h0400, 32'h0,         32'hCAFE_F00D);
    add_entry(0, 1, 1, 0, 1, 1, 16'h0406, 32'h1234_0000, 32'h0);
    add_entry(0, 0, 0, 2, 0, 1, 16'h0406, 32'h0,         32'h1234_0000);
    add_entry(0, 4, 2, 0, 0, 0, 16'h0403, 32'h0,         32'hCA00_0000);
    add_entry(1, 0, 0, 0, 0, 2, 16'h0100, 32'h0,         32'h4433_2211);
    add_entry(1, 0, 0, 0, 1, 0, 16'h0102, 32'h0077_0000, 32'h0);
    add_entry(1, 0, 0, 0, 0, 2, 16'h0100, 32'h0,         32'h4477_2211);
    add_entry(0, 1, 1, 1, 1, 0, 16'h0401, 32'h0000_5500, 32'h0);
    add_entry(0, 1, 1, 1, 0, 2, 16'h0400, 32'h0,         32'hCAFE_550D);
    add_entry(1, 7, 7, 3, 1, 2, 16'h0500, 32'h89AB_CDEF, 32'h0);
    add_entry(1, 7, 7, 3, 0, 2, 16'h0500, 32'h0,         32'h89AB_CDEF);

    repeat (4) @(posedge HCLK);
    check_idle_pins();  // Still in reset
    HRESETn <= 1'b1;
    @(posedge HCLK);
    @(posedge HCLK);
    check_idle_pins();
    $display("test reset %s", (errors == 0) ? "ok" : "mismatch");

    for (int t = 0; t < N_TAB; t++)
    begin
      err0 = errors;
      run_transfer(t_port[t], t_rc[t], t_wc[t], t_tc[t], t_wr[t], t_size[t], t_addr[t],
                   t_wdata[t], 0);
      if (t_wr[t]) record_write(t_size[t], t_addr[t], t_wdata[t]);
      else check("hrdata", hrdata & lane_mask(t_size[t], t_addr[t]),
                 t_exp[t] & lane_mask(t_size[t], t_addr[t]));
      $display("test %0d %s size %0d addr %h %s", t, t_wr[t] ? "write" : "read",
               t_size[t], t_addr[t], (errors == err0) ? "ok" : "mismatch");
    end

    // Random traffic against the shadow array
    for (int r = 0; r < N_RAND; r++)
    begin
      err0 = errors;
      sz   = 3'({$random(seed)} % 3);
      rnd  = $random(seed);
      a    = (16'h1000 | {8'h00, rnd[7:0]}) & ~((16'd1 << sz) - 16'd1);
      p    = rnd[8];
      wr   = rnd[9];
      rc   = rnd[12:10];
      wc   = rnd[15:13];
      tc   = rnd[18:16];
      gaps = int'(rnd[20:19]);
      wd   = $random(seed);
      run_transfer(p, rc, wc, tc, wr, sz, a, wd, gaps);
      if (wr) record_write(sz, a, wd);
      else check("hrdata", hrdata & lane_mask(sz, a), shadow_word(a) & lane_mask(sz, a));
      $display("test random %0d %s size %0d addr %h %s", r, wr ? "write" : "read", sz, a,
               (errors == err0) ? "ok" : "mismatch");
    end

    $display("tests run %0d, errors %0d", N_TAB + N_RAND + 1, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== compile.f ====
ahb_pkg.sv
ext_mem_pkg.sv
ahb_access_ctrl.sv
data_lane_router.sv
mem_cycle_fsm.sv
ahb_to_extmem.sv
tb_ahb_to_extmem.sv

// ==== Makefile ====
# Verilator build and run for the AHB to SRAM bridge

VERILATOR ?= verilator
TOP       ?= tb_ahb_to_extmem
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
